/* include/nts_verify_macros.svh */
`ifndef NTS_VERIFY_MACROS_SVH
`define NTS_VERIFY_MACROS_SVH

//--------------------------------------------------------------------------
// Bus widths
//--------------------------------------------------------------------------

`define NTS_RX_ADDR_W  11   // RX buffer byte address
`define NTS_BYTES_W    10   // Copy length in bytes
`define NTS_WORD_W     64   // Working memory word
`define NTS_KEY_W      256  // AES-SIV-CMAC-256 key

//--------------------------------------------------------------------------
// Working memory layout
//--------------------------------------------------------------------------

`define NTS_MEM_ADDR_W 8    // 256 words of 64 bits

// Word addresses, both even so a pair forms one engine block
`define NTS_MEM_NONCE  4    // Nonce pair, engine block 2
`define NTS_MEM_AD     8    // Associated data, engine block 4 onwards

`endif

/* source/nts_ctrl_pkg.sv */
`include "nts_verify_macros.svh"

package nts_ctrl_pkg;

  // One-hot operation strobes plus the RX copy window
  typedef struct packed {
    logic                      copy_ad;       // RX to memory at AD base
    logic                      copy_nonce;    // RX to memory at nonce base
    logic                      copy_tag;      // RX to tag registers
    logic                      verify;        // Start engine in decrypt mode
    logic                      generate_tag;  // Store prefetched nonce pair
    logic [`NTS_RX_ADDR_W-1:0] rx_addr;       // First byte in RX buffer
    logic [`NTS_BYTES_W-1:0]   rx_bytes;      // Bytes to copy
  } nts_op_t;

  // Sequencer state, also selects the memory owner
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RX_INIT,        // First RX read pending
    ST_RX_COPY,        // Words go to working memory
    ST_RX_TAG,         // Words go to tag registers
    ST_VERIFY_WAIT0,   // Engine start in flight
    ST_VERIFY_WAIT1,   // Waiting for engine ready
    ST_NONCE_STORE,    // Pair write, both memory ports
    ST_ERROR           // Rejected operation
  } nts_state_t;

  typedef struct packed {
    logic                      rd_en;
    logic [`NTS_RX_ADDR_W-1:0] addr;
  } nts_rx_req_t;

endpackage

/* source/nts_mem_pkg.sv */
`include "nts_verify_macros.svh"

package nts_mem_pkg;

  typedef logic [`NTS_MEM_ADDR_W-1:0] nts_mem_addr_t;
  typedef logic [`NTS_WORD_W-1:0]     nts_word_t;

  // Single word write into one memory port
  typedef struct packed {
    logic          en;
    logic          we;
    nts_mem_addr_t addr;
    nts_word_t     data;
  } nts_mem_wr_t;

  typedef struct packed {
    nts_word_t msb;   // Even word address
    nts_word_t lsb;   // Odd word address
  } nts_block_words_t;

  // Engine sees one 128-bit block, memory sees two words
  typedef union packed {
    logic [2*`NTS_WORD_W-1:0] block;
    nts_block_words_t         w;
  } nts_block_u;

endpackage

/* source/nts_verify_seq.sv */
`include "nts_verify_macros.svh"

module nts_verify_seq (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  nts_ctrl_pkg::nts_op_t    i_op,
  input  logic                     i_rx_done,
  input  logic                     i_nonce_pair_valid,
  input  logic                     i_core_ready,
  input  logic                     i_core_tag_ok,
  output nts_ctrl_pkg::nts_state_t o_state,
  output logic                     o_core_start,
  output logic [19:0]              o_core_ad_length,
  output logic                     o_busy,
  output logic                     o_verify_tag_ok
);

  nts_ctrl_pkg::nts_state_t state_q;
  nts_ctrl_pkg::nts_state_t state_d;
  logic        tag_mode_q;   // Current RX copy targets the tag registers
  logic [19:0] ad_len_q;
  logic        start_q;
  logic        tag_ok_q;
  logic        idle;
  logic        copy_acc;     // Any RX copy accepted
  logic        verify_acc;

  assign idle       = (state_q == nts_ctrl_pkg::ST_IDLE);
  assign copy_acc   = idle && (i_op.copy_ad || i_op.copy_nonce || i_op.copy_tag);
  assign verify_acc = idle && !copy_acc && i_op.verify;   // Copies win

  //--------------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      nts_ctrl_pkg::ST_IDLE: begin
        if (copy_acc) state_d = nts_ctrl_pkg::ST_RX_INIT;
        else if (verify_acc) state_d = nts_ctrl_pkg::ST_VERIFY_WAIT0;
        else if (i_op.generate_tag) begin
          state_d = i_nonce_pair_valid ? nts_ctrl_pkg::ST_NONCE_STORE
                                       : nts_ctrl_pkg::ST_ERROR;
        end
      end
      nts_ctrl_pkg::ST_RX_INIT: begin
        // Copier holds the first read until wait drops
        if (i_rx_done) state_d = nts_ctrl_pkg::ST_IDLE;
        else state_d = tag_mode_q ? nts_ctrl_pkg::ST_RX_TAG : nts_ctrl_pkg::ST_RX_COPY;
      end
      nts_ctrl_pkg::ST_RX_COPY,
      nts_ctrl_pkg::ST_RX_TAG:       if (i_rx_done) state_d = nts_ctrl_pkg::ST_IDLE;
      nts_ctrl_pkg::ST_VERIFY_WAIT0: state_d = nts_ctrl_pkg::ST_VERIFY_WAIT1;
      nts_ctrl_pkg::ST_VERIFY_WAIT1: if (i_core_ready) state_d = nts_ctrl_pkg::ST_IDLE;
      default:                       state_d = nts_ctrl_pkg::ST_IDLE;   // Store, error
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q    <= nts_ctrl_pkg::ST_IDLE;
      tag_mode_q <= 1'b0;
      ad_len_q   <= '0;
      start_q    <= 1'b0;
      tag_ok_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      start_q <= verify_acc;                          // One-cycle engine start
      if (copy_acc) tag_mode_q <= !i_op.copy_ad && !i_op.copy_nonce && i_op.copy_tag;
      if (idle && i_op.copy_ad) ad_len_q <= {10'b0, i_op.rx_bytes};
      if (verify_acc) tag_ok_q <= 1'b0;               // Stale result cleared
      else if (state_q == nts_ctrl_pkg::ST_VERIFY_WAIT1 && i_core_ready) begin
        tag_ok_q <= i_core_tag_ok;
      end
    end
  end

  assign o_state          = state_q;
  assign o_core_start     = start_q;
  assign o_core_ad_length = ad_len_q;
  assign o_busy           = !idle;
  assign o_verify_tag_ok  = tag_ok_q;

  // Every consumer decodes the state so it must never go unknown
  a_state_known: assert property (@(posedge i_clk) disable iff (i_areset)
    !$isunknown(state_q));

endmodule

/* source/nts_rx_copier.sv */
`include "nts_verify_macros.svh"

module nts_rx_copier (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  nts_ctrl_pkg::nts_op_t     i_op,
  input  nts_ctrl_pkg::nts_state_t  i_state,
  input  logic                      i_rx_wait,
  input  logic                      i_rx_rd_dv,
  input  nts_mem_pkg::nts_word_t    i_rx_rd_data,
  output nts_ctrl_pkg::nts_rx_req_t o_rx_req,
  output nts_mem_pkg::nts_mem_wr_t  o_mem_wr,
  output logic [1:0]                o_tag_we,
  output nts_mem_pkg::nts_word_t    o_tag_word,
  output logic                      o_done
);

  logic [`NTS_RX_ADDR_W-1:0]  next_q;       // Next RX byte address to read
  logic [`NTS_RX_ADDR_W-1:0]  last_q;       // End of copy window
  nts_mem_pkg::nts_mem_addr_t mem_addr_q;
  logic                       first_q;      // First read not yet issued
  logic                       tag_idx_q;    // 0 msb word, 1 lsb word
  logic                       accept;
  logic                       active;
  logic                       word_dv;
  logic                       step;         // Read issued this cycle
  logic                       mem_we;
  logic                       tag_we;

  assign accept = (i_state == nts_ctrl_pkg::ST_IDLE) &&
                  (i_op.copy_ad || i_op.copy_nonce || i_op.copy_tag);
  assign active = i_state inside {nts_ctrl_pkg::ST_RX_INIT, nts_ctrl_pkg::ST_RX_COPY,
                                  nts_ctrl_pkg::ST_RX_TAG};
  assign word_dv = !i_rx_wait && i_rx_rd_dv && !first_q;   // Nothing valid before 1st read
  assign step    = active && !i_rx_wait && (first_q || i_rx_rd_dv);   // Wait stalls all
  assign mem_we  = word_dv && (i_state == nts_ctrl_pkg::ST_RX_COPY);
  assign tag_we  = word_dv && (i_state == nts_ctrl_pkg::ST_RX_TAG);

  //--------------------------------------------------------------------------
  // Address walk
  //--------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      next_q     <= '0;
      last_q     <= '0;
      mem_addr_q <= '0;
      first_q    <= 1'b0;
      tag_idx_q  <= 1'b0;
    end else if (accept) begin
      next_q     <= i_op.rx_addr;
      last_q     <= i_op.rx_addr + {1'b0, i_op.rx_bytes};
      mem_addr_q <= i_op.copy_ad ? nts_mem_pkg::nts_mem_addr_t'(`NTS_MEM_AD)
                                 : nts_mem_pkg::nts_mem_addr_t'(`NTS_MEM_NONCE);
      first_q    <= 1'b1;
      tag_idx_q  <= 1'b0;
    end else begin
      if (step) begin
        next_q  <= next_q + `NTS_RX_ADDR_W'(8);   // 64-bit reads
        first_q <= 1'b0;
      end
      if (mem_we) mem_addr_q <= mem_addr_q + nts_mem_pkg::nts_mem_addr_t'(1);
      if (tag_we) tag_idx_q <= !tag_idx_q;
    end
  end

  assign o_rx_req   = '{rd_en: step, addr: next_q};
  assign o_mem_wr   = '{en: mem_we, we: mem_we, addr: mem_addr_q, data: i_rx_rd_data};
  assign o_tag_we   = {tag_we && tag_idx_q, tag_we && !tag_idx_q};
  assign o_tag_word = i_rx_rd_data;
  assign o_done     = step && (next_q >= last_q);   // Read at or past the window end

  // RX data only answers a read that was issued
  a_dv_after_rd: assert property (@(posedge i_clk) disable iff (i_areset)
    $rose(i_rx_rd_dv) |-> $past(step));

endmodule

/* source/nts_nonce_prefetch.sv */
`include "nts_verify_macros.svh"

module nts_nonce_prefetch (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  nts_ctrl_pkg::nts_state_t i_state,
  output logic                     o_noncegen_get,
  input  logic                     i_noncegen_ready,
  input  nts_mem_pkg::nts_word_t   i_noncegen_nonce,
  output logic                     o_pair_valid,
  output nts_mem_pkg::nts_mem_wr_t o_mem_wr_a,
  output nts_mem_pkg::nts_mem_wr_t o_mem_wr_b
);

  logic                   get_q;       // Request held until ready
  logic                   a_vld_q;
  logic                   b_vld_q;
  nts_mem_pkg::nts_word_t nonce_a_q;
  nts_mem_pkg::nts_word_t nonce_b_q;
  logic                   store;
  logic                   take;        // Generator word accepted

  assign store = (i_state == nts_ctrl_pkg::ST_NONCE_STORE);
  assign take  = !store && get_q && i_noncegen_ready;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      get_q   <= 1'b0;
      a_vld_q <= 1'b0;
      b_vld_q <= 1'b0;
    end else if (store) begin
      a_vld_q <= 1'b0;                 // Pair consumed
      b_vld_q <= 1'b0;
    end else if (take) begin
      get_q <= 1'b0;
      if (!a_vld_q) a_vld_q <= 1'b1;   // Slot a fills first
      else          b_vld_q <= 1'b1;
    end else if (!a_vld_q || !b_vld_q) begin
      get_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take && !a_vld_q)     nonce_a_q <= i_noncegen_nonce;
    else if (take && !b_vld_q) nonce_b_q <= i_noncegen_nonce;
  end

  assign o_noncegen_get = get_q;
  assign o_pair_valid   = a_vld_q && b_vld_q;

  // Both words in one cycle, a as block msb
  assign o_mem_wr_a = '{en: store, we: store, data: nonce_a_q,
                        addr: nts_mem_pkg::nts_mem_addr_t'(`NTS_MEM_NONCE)};
  assign o_mem_wr_b = '{en: store, we: store, data: nonce_b_q,
                        addr: nts_mem_pkg::nts_mem_addr_t'(`NTS_MEM_NONCE + 1)};

endmodule

/* source/nts_work_mem.sv */
`include "nts_verify_macros.svh"

module nts_work_mem (
  input  logic                     i_clk,
  input  nts_ctrl_pkg::nts_state_t i_state,
  input  nts_mem_pkg::nts_mem_wr_t i_rx_wr,
  input  nts_mem_pkg::nts_mem_wr_t i_nonce_wr_a,
  input  nts_mem_pkg::nts_mem_wr_t i_nonce_wr_b,
  input  logic                     i_core_cs,
  input  logic                     i_core_we,
  input  logic [15:0]              i_core_addr,
  input  nts_mem_pkg::nts_block_u  i_core_block_wr,
  output nts_mem_pkg::nts_block_u  o_core_block_rd
);

  nts_mem_pkg::nts_word_t   mem [2**`NTS_MEM_ADDR_W];
  nts_mem_pkg::nts_mem_wr_t port_a;
  nts_mem_pkg::nts_mem_wr_t port_b;
  nts_mem_pkg::nts_word_t   rd_a_q;
  nts_mem_pkg::nts_word_t   rd_b_q;

  //--------------------------------------------------------------------------
  // Port mux, engine owns memory outside the copy and store states
  //--------------------------------------------------------------------------

  always_comb begin
    port_a = '0;
    port_b = '0;
    case (i_state)
      nts_ctrl_pkg::ST_RX_COPY: port_a = i_rx_wr;   // 64-bit writes on A only
      nts_ctrl_pkg::ST_NONCE_STORE: begin
        port_a = i_nonce_wr_a;
        port_b = i_nonce_wr_b;
      end
      default: begin
        // Block n splits into words 2n and 2n+1
        port_a = '{en: i_core_cs, we: i_core_we, data: i_core_block_wr.w.msb,
                   addr: {i_core_addr[`NTS_MEM_ADDR_W-2:0], 1'b0}};
        port_b = '{en: i_core_cs, we: i_core_we, data: i_core_block_wr.w.lsb,
                   addr: {i_core_addr[`NTS_MEM_ADDR_W-2:0], 1'b1}};
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (port_a.en) begin
      if (port_a.we) mem[port_a.addr] <= port_a.data;
      rd_a_q <= mem[port_a.addr];   // Read before write
    end
    if (port_b.en) begin
      if (port_b.we) mem[port_b.addr] <= port_b.data;
      rd_b_q <= mem[port_b.addr];
    end
  end

  always_comb begin
    o_core_block_rd.w.msb = rd_a_q;
    o_core_block_rd.w.lsb = rd_b_q;
  end

  // Engine must stay off the memory while the sequencer has handed it away
  a_core_owns_mem: assert property (@(posedge i_clk)
    i_core_cs |-> !(i_state inside {nts_ctrl_pkg::ST_RX_COPY, nts_ctrl_pkg::ST_NONCE_STORE}));

endmodule

/* source/nts_siv_port.sv */
`include "nts_verify_macros.svh"

module nts_siv_port (
  input  logic                    i_clk,
  input  logic                    i_areset,
  input  logic                    i_unwrapped_c2s,
  input  logic [2:0]              i_unwrapped_word,
  input  logic [31:0]             i_unwrapped_data,
  input  logic [1:0]              i_tag_we,
  input  nts_mem_pkg::nts_word_t  i_tag_word,
  input  logic                    i_core_cs,
  output logic [`NTS_KEY_W-1:0]   o_core_key,
  output nts_mem_pkg::nts_block_u o_core_tag,
  output logic                    o_core_ack
);

  logic [`NTS_KEY_W-1:0]  key_q;      // Client-to-server key
  nts_mem_pkg::nts_word_t tag_q [2];  // Received tag, [0] is msb
  logic                   ack_q;

  always_ff @(posedge i_clk) begin
    if (i_unwrapped_c2s) key_q[{i_unwrapped_word, 5'b0} +: 32] <= i_unwrapped_data;
    if (i_tag_we[0]) tag_q[0] <= i_tag_word;
    if (i_tag_we[1]) tag_q[1] <= i_tag_word;
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) ack_q <= 1'b0;
    else          ack_q <= i_core_cs;   // Memory answers one cycle after cs
  end

  assign o_core_key = key_q;   // 256-bit mode only
  assign o_core_ack = ack_q;

  always_comb begin
    o_core_tag.w.msb = tag_q[0];
    o_core_tag.w.lsb = tag_q[1];
  end

endmodule

/* source/nts_verify_top.sv */
`include "nts_verify_macros.svh"

module nts_verify_top (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  nts_ctrl_pkg::nts_op_t     i_op,
  input  logic                      i_unwrapped_c2s,
  input  logic [2:0]                i_unwrapped_word,
  input  logic [31:0]               i_unwrapped_data,
  output nts_ctrl_pkg::nts_rx_req_t o_rx_req,
  input  logic                      i_rx_wait,
  input  logic                      i_rx_rd_dv,
  input  nts_mem_pkg::nts_word_t    i_rx_rd_data,
  output logic                      o_noncegen_get,
  input  logic                      i_noncegen_ready,
  input  nts_mem_pkg::nts_word_t    i_noncegen_nonce,
  input  logic                      i_core_cs,
  input  logic                      i_core_we,
  input  logic [15:0]               i_core_addr,
  input  nts_mem_pkg::nts_block_u   i_core_block_wr,
  output nts_mem_pkg::nts_block_u   o_core_block_rd,
  output logic                      o_core_ack,
  output logic                      o_core_start,
  output logic [19:0]               o_core_ad_length,
  output logic [`NTS_KEY_W-1:0]     o_core_key,
  output nts_mem_pkg::nts_block_u   o_core_tag,
  input  logic                      i_core_ready,
  input  logic                      i_core_tag_ok,
  output logic                      o_busy,
  output logic                      o_verify_tag_ok
);

  nts_ctrl_pkg::nts_state_t state;        // Shared by all blocks
  logic                     rx_done;
  logic                     pair_valid;
  nts_mem_pkg::nts_mem_wr_t rx_wr;
  nts_mem_pkg::nts_mem_wr_t nonce_wr_a;
  nts_mem_pkg::nts_mem_wr_t nonce_wr_b;
  logic [1:0]               tag_we;
  nts_mem_pkg::nts_word_t   tag_word;

  nts_verify_seq u_seq (
    .i_clk, .i_areset, .i_op, .i_rx_done(rx_done), .i_nonce_pair_valid(pair_valid),
    .i_core_ready, .i_core_tag_ok, .o_state(state), .o_core_start,
    .o_core_ad_length, .o_busy, .o_verify_tag_ok);

  nts_rx_copier u_rx_copier (
    .i_clk, .i_areset, .i_op, .i_state(state), .i_rx_wait, .i_rx_rd_dv, .i_rx_rd_data,
    .o_rx_req, .o_mem_wr(rx_wr), .o_tag_we(tag_we), .o_tag_word(tag_word),
    .o_done(rx_done));

  nts_nonce_prefetch u_nonce_prefetch (
    .i_clk, .i_areset, .i_state(state), .o_noncegen_get, .i_noncegen_ready,
    .i_noncegen_nonce, .o_pair_valid(pair_valid), .o_mem_wr_a(nonce_wr_a),
    .o_mem_wr_b(nonce_wr_b));

  nts_work_mem u_work_mem (
    .i_clk, .i_state(state), .i_rx_wr(rx_wr), .i_nonce_wr_a(nonce_wr_a),
    .i_nonce_wr_b(nonce_wr_b), .i_core_cs, .i_core_we, .i_core_addr,
    .i_core_block_wr, .o_core_block_rd);

  nts_siv_port u_siv_port (
    .i_clk, .i_areset, .i_unwrapped_c2s, .i_unwrapped_word, .i_unwrapped_data,
    .i_tag_we(tag_we), .i_tag_word(tag_word), .i_core_cs, .o_core_key, .o_core_tag,
    .o_core_ack);

endmodule

/* sim/tb_rx_buffer.sv */
`include "nts_verify_macros.svh"

module tb_rx_buffer (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_stall,       // Wait request from the testbench
  input  logic [63:0]               i_salt,        // Mixed into every data word
  input  nts_ctrl_pkg::nts_rx_req_t i_rx_req,
  output logic                      o_rx_wait,
  output logic                      o_rx_rd_dv,
  output nts_mem_pkg::nts_word_t    o_rx_rd_data
);

  timeunit 1ns;
  timeprecision 100ps;

  // Word stored at a byte address, every address bit shows in both halves
  function automatic nts_mem_pkg::nts_word_t word_at(input logic [`NTS_RX_ADDR_W-1:0] a);
    return {i_salt[63:32] ^ {21'b0, a}, i_salt[31:0] ^ ~{21'b0, a}};
  endfunction

  assign o_rx_wait = i_stall;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      o_rx_rd_dv   <= 1'b0;
      o_rx_rd_data <= '0;
    end else if (i_rx_req.rd_en) begin
      o_rx_rd_dv   <= 1'b1;                       // Data one cycle after the read
      o_rx_rd_data <= word_at(i_rx_req.addr);
    end else if (!i_stall) begin
      o_rx_rd_dv <= 1'b0;                         // Held through a stall
    end
  end

endmodule

/* sim/tb_nts_verify.sv */
`include "nts_verify_macros.svh"

module tb_nts_verify;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [10:0] AD_RX  = 11'h040;   // RX byte addresses of the copies
  localparam logic [10:0] TAG_RX = 11'h100;
  localparam logic [10:0] BAD_RX = 11'h180;
  localparam int AD_BLK    = `NTS_MEM_AD / 2;
  localparam int NONCE_BLK = `NTS_MEM_NONCE / 2;

  logic clk = 1'b0;
  logic areset;
  nts_ctrl_pkg::nts_op_t     op;
  logic                      c2s, stall, stall_en, core_cs, core_we, ready, tag_ok;
  logic [2:0]                key_idx;
  logic [31:0]               key_word;
  nts_ctrl_pkg::nts_rx_req_t rx_req;
  logic                      rx_wait, rx_dv, noncegen_get, noncegen_ready;
  nts_mem_pkg::nts_word_t    rx_data, nonce;
  logic [15:0]               core_addr;
  nts_mem_pkg::nts_block_u   block_wr, block_rd, core_tag;
  logic                      core_ack, core_start, busy, verify_ok;
  logic [19:0]               ad_length;
  logic [255:0]              core_key;
  logic [31:0]               lfsr_q;
  logic [63:0]               salt;
  nts_mem_pkg::nts_word_t    served[$];        // Nonces handed to the DUT, in order
  int                        nonce_cnt, checks, errors;
  logic                      chk_en;           // Value compare strobe
  string                     chk_name;
  logic [255:0]              chk_got, chk_exp;

  always #20 clk = !clk;

  nts_verify_top u_nts_verify_top (
    .i_clk(clk), .i_areset(areset), .i_op(op), .i_unwrapped_c2s(c2s),
    .i_unwrapped_word(key_idx), .i_unwrapped_data(key_word), .o_rx_req(rx_req),
    .i_rx_wait(rx_wait), .i_rx_rd_dv(rx_dv), .i_rx_rd_data(rx_data),
    .o_noncegen_get(noncegen_get), .i_noncegen_ready(noncegen_ready),
    .i_noncegen_nonce(nonce), .i_core_cs(core_cs), .i_core_we(core_we),
    .i_core_addr(core_addr), .i_core_block_wr(block_wr), .o_core_block_rd(block_rd),
    .o_core_ack(core_ack), .o_core_start(core_start), .o_core_ad_length(ad_length),
    .o_core_key(core_key), .o_core_tag(core_tag), .i_core_ready(ready),
    .i_core_tag_ok(tag_ok), .o_busy(busy), .o_verify_tag_ok(verify_ok));

  tb_rx_buffer u_rx_buffer (
    .i_clk(clk), .i_areset(areset), .i_stall(stall), .i_salt(salt), .i_rx_req(rx_req),
    .o_rx_wait(rx_wait), .o_rx_rd_dv(rx_dv), .o_rx_rd_data(rx_data));

  //--------------------------------------------------------------------------
  // Reporting and stimulus helpers
  //--------------------------------------------------------------------------

  task automatic report_mismatch(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
    errors++;
    $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;                                        // Inputs change after the edge
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per returned bit
  function automatic logic [63:0] get_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic nts_mem_pkg::nts_word_t rx_word(input logic [10:0] a);
    return {salt[63:32] ^ {21'b0, a}, salt[31:0] ^ ~{21'b0, a}};
  endfunction

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    checks++;
    chk_name = name;
    chk_got  = got;
    chk_exp  = exp;
    chk_en   = 1'b1;
    next_cycle();
    chk_en   = 1'b0;
  endtask

  task automatic wait_idle(input string what);
    int cnt;
    cnt = 0;
    while (busy && cnt < 300) begin
      cnt++;
      next_cycle();
    end
    if (busy) report_problem({"busy never fell after ", what});
  endtask

  task automatic run_copy(input int kind, input logic [10:0] addr, input int bytes);
    op = '0;
    op.copy_ad  = (kind == 0);
    op.copy_tag = (kind == 1);
    op.rx_addr  = addr;
    op.rx_bytes = 10'(bytes);
    next_cycle();
    op = '0;
    wait_idle("an RX copy");
  endtask

  // Engine side block read, data is taken with the acknowledge
  task automatic read_block(input int blk, output logic [127:0] data);
    int cnt;
    cnt       = 0;
    core_cs   = 1'b1;
    core_addr = 16'(blk);
    next_cycle();
    core_cs = 1'b0;
    while (!core_ack && cnt < 20) begin
      cnt++;
      next_cycle();
    end
    if (!core_ack) report_problem("no acknowledge for an engine read");
    data = block_rd.block;
  endtask

  task automatic run_generate();
    int cycles;
    op.generate_tag = 1'b1;
    next_cycle();
    op     = '0;
    cycles = 1;                                // Acceptance cycle counts
    while (busy && cycles < 20) begin
      cycles++;
      next_cycle();
    end
    check_value("generate busy cycles", 256'(cycles), 256'(2));
  endtask

  // Engine model, tag reference is AD blocks, nonce block and both key halves
  task automatic run_verify(input logic exp_ok);
    int cnt;
    logic [127:0] b4, b5, bn, ref_tag;
    cnt = 0;
    op.verify = 1'b1;
    next_cycle();
    op = '0;
    while (!core_start && cnt < 10) begin
      cnt++;
      next_cycle();
    end
    if (!core_start) report_problem("engine start never came");
    read_block(AD_BLK, b4);
    read_block(AD_BLK + 1, b5);
    read_block(NONCE_BLK, bn);
    ref_tag = b4 ^ b5 ^ bn ^ core_key[255:128] ^ core_key[127:0];
    ready  = 1'b1;
    tag_ok = (ref_tag == core_tag.block);
    next_cycle();
    ready  = 1'b0;
    tag_ok = 1'b0;
    wait_idle("a verify");
    check_value("o_verify_tag_ok", 256'(verify_ok), 256'(exp_ok));
  endtask

  //--------------------------------------------------------------------------
  // Nonce generator and stall source
  //--------------------------------------------------------------------------

  always @(posedge clk) begin
    #2;
    if (noncegen_ready) noncegen_ready = 1'b0;   // One word per request
    else if (noncegen_get && !areset) begin
      nonce = {32'hC0DE5EED ^ 32'(nonce_cnt), ~32'(nonce_cnt)};
      served.push_back(nonce);
      nonce_cnt++;
      noncegen_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    logic [63:0] b;
    #2;
    if (stall_en) begin
      b     = get_bits(2);
      stall = &b[1:0];                         // About one cycle in four
    end else stall = 1'b0;
  end

  //--------------------------------------------------------------------------
  // Checkers
  //--------------------------------------------------------------------------

  a_reset_quiet: assert property (@(posedge clk)
    $fell(areset) |-> !busy && !core_start && !verify_ok && !core_ack && !rx_req.rd_en)
    else report_problem("outputs not idle right after reset");
  a_ack_after_cs: assert property (@(posedge clk) disable iff (areset) core_cs |=> core_ack)
    else report_mismatch("o_core_ack", 256'(core_ack), 256'(1));
  a_start_after_accept: assert property (@(posedge clk) disable iff (areset)
    (op.verify && !busy) |=> core_start)
    else report_mismatch("o_core_start", 256'(core_start), 256'(1));
  a_start_single: assert property (@(posedge clk) disable iff (areset)
    core_start |=> !core_start)
    else report_problem("engine start longer than one cycle");
  a_value: assert property (@(posedge clk) chk_en |-> chk_got == chk_exp)
    else report_mismatch(chk_name, chk_got, chk_exp);

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------

  initial begin
    int cnt;
    logic [127:0] ad4, ad5, blk, tag_good, key_hi;
    logic [127:0] ad4_exp, ad5_exp, nonce_exp;
    logic [255:0] key;
    areset         = 1'b1;
    op             = '0;
    c2s            = 1'b0;
    key_idx        = '0;
    key_word       = '0;
    stall          = 1'b0;
    stall_en       = 1'b0;
    core_cs        = 1'b0;
    core_we        = 1'b0;
    core_addr      = '0;
    block_wr       = '0;
    ready          = 1'b0;
    tag_ok         = 1'b0;
    noncegen_ready = 1'b0;
    nonce          = '0;
    chk_en         = 1'b0;
    chk_got        = '0;
    chk_exp        = '0;
    nonce_cnt      = 0;
    checks         = 0;
    errors         = 0;
    lfsr_q         = 32'h7618;
    salt           = get_bits(64);
    key_hi[127:64] = get_bits(64);
    key_hi[63:0]   = get_bits(64);
    repeat (2) @(posedge clk);
    #2 areset = 1'b0;

    cnt = 0;                                   // Prefetch starts on its own
    while (!noncegen_get && cnt < 10) begin
      cnt++;
      next_cycle();
    end
    if (!noncegen_get) report_problem("nonce request never rose after reset");

    stall_en = 1'b1;                           // AD copy with stalls
    run_copy(0, AD_RX, 32);
    stall_en = 1'b0;
    next_cycle();
    ad4_exp = {rx_word(AD_RX), rx_word(AD_RX + 8)};
    ad5_exp = {rx_word(AD_RX + 16), rx_word(AD_RX + 24)};
    read_block(AD_BLK, ad4);
    check_value("AD block 4", 256'(ad4), 256'(ad4_exp));
    read_block(AD_BLK + 1, ad5);
    check_value("AD block 5", 256'(ad5), 256'(ad5_exp));
    check_value("o_core_ad_length", 256'(ad_length), 256'(32));

    run_copy(1, TAG_RX, 16);
    tag_good = {rx_word(TAG_RX), rx_word(TAG_RX + 8)};
    check_value("o_core_tag", 256'(core_tag.block), 256'(tag_good));

    cnt = 0;
    while (served.size() < 2 && cnt < 40) begin
      cnt++;
      next_cycle();
    end
    if (served.size() < 2) report_problem("nonce generator served fewer than two nonces");
    repeat (2) next_cycle();                   // Second word taken into slot b
    run_generate();
    run_generate();                            // Slots are empty again
    nonce_exp = {served[0], served[1]};
    read_block(NONCE_BLK, blk);
    check_value("nonce block 2", 256'(blk), 256'(nonce_exp));

    key = {key_hi, tag_good ^ ad4_exp ^ ad5_exp ^ nonce_exp ^ key_hi};   // Tag matches
    for (int i = 0; i < 8; i++) begin
      c2s      = 1'b1;
      key_idx  = 3'(i);
      key_word = key[32*i +: 32];
      next_cycle();
    end
    c2s = 1'b0;
    check_value("o_core_key", core_key, key);

    run_verify(1'b1);
    run_copy(1, BAD_RX, 16);
    check_value("o_core_tag", 256'(core_tag.block),
                256'({rx_word(BAD_RX), rx_word(BAD_RX + 8)}));
    run_verify(1'b0);

    next_cycle();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+include
source/nts_ctrl_pkg.sv
source/nts_mem_pkg.sv
source/nts_verify_seq.sv
source/nts_rx_copier.sv
source/nts_nonce_prefetch.sv
source/nts_work_mem.sv
source/nts_siv_port.sv
source/nts_verify_top.sv
sim/tb_rx_buffer.sv
sim/tb_nts_verify.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
  --top-module tb_nts_verify -o tb_nts_verify
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_nts_verify)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
